//--- decode_unit.sv
`default_nettype none
`include "riscv_params.svh"

module decode_unit (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       redirect_i,
   input  wire                       fd_valid_i,
   input  wire riscv_pkg::word_t     fd_pc_i,
   input  wire riscv_pkg::word_t     fd_instr_i,
   output riscv_pkg::reg_addr_t      rs1_addr_o,
   output riscv_pkg::reg_addr_t      rs2_addr_o,
   input  wire riscv_pkg::word_t     rs1_data_i,
   input  wire riscv_pkg::word_t     rs2_data_i,
   output logic                      de_valid_o,
   output riscv_pkg::word_t          de_pc_o,
   output riscv_pkg::reg_addr_t      de_rs1_o,
   output riscv_pkg::reg_addr_t      de_rs2_o,
   output riscv_pkg::reg_addr_t      de_rd_o,
   output riscv_pkg::word_t          de_op_a_o,
   output riscv_pkg::word_t          de_op_b_reg_o,
   output riscv_pkg::word_t          de_imm_o,
   output riscv_pkg::alu_op_t        de_alu_op_o,
   output logic                      de_use_imm_o,
   output logic                      de_reg_write_o,
   output logic                      de_mem_read_o,
   output logic                      de_mem_write_o,
   output logic                      de_branch_o,
   output logic                      de_branch_ne_o,
   output logic                      de_jump_o,
   output logic                      de_lui_o
);
   import riscv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       funct7_30;
   word_t      imm_i, imm_s, imm_b, imm_j, imm_u;

   word_t   ctl_imm;
   alu_op_t ctl_alu_op;
   logic    ctl_use_imm, ctl_reg_write, ctl_mem_read, ctl_mem_write;
   logic    ctl_branch, ctl_branch_ne, ctl_jump, ctl_lui;

   assign opcode     = fd_instr_i[6:0];
   assign funct3     = fd_instr_i[14:12];
   assign funct7_30  = fd_instr_i[30];
   assign rs1_addr_o = fd_instr_i[19:15];
   assign rs2_addr_o = fd_instr_i[24:20];

   // immediate formats, all sign extended from bit 31
   assign imm_i = {{20{fd_instr_i[31]}}, fd_instr_i[31:20]};
   assign imm_s = {{20{fd_instr_i[31]}}, fd_instr_i[31:25], fd_instr_i[11:7]};
   assign imm_b = {{19{fd_instr_i[31]}}, fd_instr_i[31], fd_instr_i[7],
                   fd_instr_i[30:25], fd_instr_i[11:8], 1'b0};
   assign imm_j = {{11{fd_instr_i[31]}}, fd_instr_i[31], fd_instr_i[19:12],
                   fd_instr_i[20], fd_instr_i[30:21], 1'b0};
   assign imm_u = {fd_instr_i[31:12], 12'b0};

   // anything not matched below stays a non-writing nop
   always_comb begin
      ctl_imm       = imm_i;
      ctl_alu_op    = `ALU_ADD;
      ctl_use_imm   = 1'b0;
      ctl_reg_write = 1'b0;
      ctl_mem_read  = 1'b0;
      ctl_mem_write = 1'b0;
      ctl_branch    = 1'b0;
      ctl_branch_ne = 1'b0;
      ctl_jump      = 1'b0;
      ctl_lui       = 1'b0;
      case (opcode)
         `OPC_OP, `OPC_OPIMM: begin
            ctl_use_imm   = (opcode == `OPC_OPIMM);
            ctl_reg_write = 1'b1;
            case (funct3)
               3'b000: begin
                  ctl_alu_op = (opcode == `OPC_OP && funct7_30) ? `ALU_SUB : `ALU_ADD;
               end
               3'b010: ctl_alu_op = `ALU_SLT;
               3'b100: ctl_alu_op = `ALU_XOR;
               3'b110: ctl_alu_op = `ALU_OR;
               3'b111: ctl_alu_op = `ALU_AND;
               // shifts and unsigned compares are not supported
               default: ctl_reg_write = 1'b0;
            endcase
         end
         `OPC_LUI: begin
            ctl_imm       = imm_u;
            ctl_alu_op    = `ALU_PASSB;
            ctl_use_imm   = 1'b1;
            ctl_reg_write = 1'b1;
            ctl_lui       = 1'b1;
         end
         `OPC_LOAD: begin
            ctl_use_imm   = 1'b1;
            ctl_reg_write = (funct3 == 3'b010);
            ctl_mem_read  = (funct3 == 3'b010);
         end
         `OPC_STORE: begin
            ctl_imm       = imm_s;
            ctl_use_imm   = 1'b1;
            ctl_mem_write = (funct3 == 3'b010);
         end
         `OPC_BRANCH: begin
            ctl_imm       = imm_b;
            ctl_branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
            ctl_branch_ne = (funct3 == 3'b001);
         end
         `OPC_JAL: begin
            ctl_imm       = imm_j;
            ctl_use_imm   = 1'b1;
            ctl_reg_write = 1'b1;
            ctl_jump      = 1'b1;
         end
         default: ;
      endcase
   end

   // decode/execute register, the slot is dropped on a redirect
   always_ff @(posedge clk) begin
      if (reset) begin
         de_valid_o     <= 1'b0;
         de_use_imm_o   <= 1'b0;
         de_reg_write_o <= 1'b0;
         de_mem_read_o  <= 1'b0;
         de_mem_write_o <= 1'b0;
         de_branch_o    <= 1'b0;
         de_branch_ne_o <= 1'b0;
         de_jump_o      <= 1'b0;
         de_lui_o       <= 1'b0;
      end else begin
         de_valid_o     <= fd_valid_i && !redirect_i;
         de_use_imm_o   <= ctl_use_imm;
         de_reg_write_o <= ctl_reg_write;
         de_mem_read_o  <= ctl_mem_read;
         de_mem_write_o <= ctl_mem_write;
         de_branch_o    <= ctl_branch;
         de_branch_ne_o <= ctl_branch_ne;
         de_jump_o      <= ctl_jump;
         de_lui_o       <= ctl_lui;
      end
   end

   always_ff @(posedge clk) begin
      de_pc_o       <= fd_pc_i;
      de_rs1_o      <= rs1_addr_o;
      de_rs2_o      <= rs2_addr_o;
      de_rd_o       <= fd_instr_i[11:7];
      de_op_a_o     <= rs1_data_i;
      de_op_b_reg_o <= rs2_data_i;
      de_imm_o      <= ctl_imm;
      de_alu_op_o   <= ctl_alu_op;
   end

endmodule

`default_nettype wire

//--- execute_unit.sv
`default_nettype none
`include "riscv_params.svh"

module execute_unit (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       de_valid_i,
   input  wire riscv_pkg::word_t     de_pc_i,
   input  wire riscv_pkg::reg_addr_t de_rs1_i,
   input  wire riscv_pkg::reg_addr_t de_rs2_i,
   input  wire riscv_pkg::reg_addr_t de_rd_i,
   input  wire riscv_pkg::word_t     de_op_a_i,
   input  wire riscv_pkg::word_t     de_op_b_reg_i,
   input  wire riscv_pkg::word_t     de_imm_i,
   input  wire riscv_pkg::alu_op_t   de_alu_op_i,
   input  wire                       de_use_imm_i,
   input  wire                       de_reg_write_i,
   input  wire                       de_mem_read_i,
   input  wire                       de_mem_write_i,
   input  wire                       de_branch_i,
   input  wire                       de_branch_ne_i,
   input  wire                       de_jump_i,
   input  wire                       de_lui_i,
   input  wire                       wb_we_i,
   input  wire riscv_pkg::reg_addr_t wb_rd_i,
   input  wire riscv_pkg::word_t     wb_data_i,
   output logic                      redirect_o,
   output riscv_pkg::word_t          redirect_pc_o,
   output logic                      em_valid_o,
   output riscv_pkg::word_t          em_pc_o,
   output riscv_pkg::reg_addr_t      em_rd_o,
   output riscv_pkg::word_t          em_result_o,
   output riscv_pkg::word_t          em_store_data_o,
   output logic                      em_reg_write_o,
   output logic                      em_mem_read_o,
   output logic                      em_mem_write_o
);
   import riscv_pkg::*;

   fwd_sel_t fwd_a, fwd_b;
   logic     src_a_used, src_b_used;
   word_t    op_a, op_b, alu_b, alu_out, result;
   logic     branch_taken;

   // newest producer wins, x0 and unused fields never forward
   function automatic fwd_sel_t pick_src(reg_addr_t rs, logic used);
      if (!used || rs == '0) begin
         return FWD_PIPE;
      end
      if (em_valid_o && em_reg_write_o && em_rd_o == rs) begin
         return FWD_MEM;
      end
      if (wb_we_i && wb_rd_i == rs) begin
         return FWD_WB;
      end
      return FWD_PIPE;
   endfunction

   function automatic word_t fwd_mux(fwd_sel_t sel, word_t pipe_val,
                                     word_t mem_val, word_t wb_val);
      case (sel)
         FWD_MEM: return mem_val;
         FWD_WB:  return wb_val;
         default: return pipe_val;
      endcase
   endfunction

   // lui and jal carry immediate bits in the rs fields
   assign src_a_used = !(de_lui_i || de_jump_i);
   assign src_b_used = !de_use_imm_i || de_mem_write_i;

   always_comb begin
      fwd_a = pick_src(de_rs1_i, src_a_used);
      fwd_b = pick_src(de_rs2_i, src_b_used);
   end

   assign op_a  = fwd_mux(fwd_a, de_op_a_i, em_result_o, wb_data_i);
   assign op_b  = fwd_mux(fwd_b, de_op_b_reg_i, em_result_o, wb_data_i);
   assign alu_b = de_use_imm_i ? de_imm_i : op_b;

   always_comb begin
      case (de_alu_op_i)
         `ALU_ADD:   alu_out = op_a + alu_b;
         `ALU_SUB:   alu_out = op_a - alu_b;
         `ALU_AND:   alu_out = op_a & alu_b;
         `ALU_OR:    alu_out = op_a | alu_b;
         `ALU_XOR:   alu_out = op_a ^ alu_b;
         `ALU_SLT:   alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
         `ALU_PASSB: alu_out = alu_b;
         default:    alu_out = op_a + alu_b;
      endcase
   end

   // jal links pc+4, stores get base plus offset from the alu
   assign result = de_jump_i ? de_pc_i + 32'd4 : alu_out;

   assign branch_taken  = de_branch_i && ((op_a == op_b) != de_branch_ne_i);
   assign redirect_o    = de_valid_i && (branch_taken || de_jump_i);
   assign redirect_pc_o = de_pc_i + de_imm_i;

   // execute/memory register
   always_ff @(posedge clk) begin
      if (reset) begin
         em_valid_o     <= 1'b0;
         em_reg_write_o <= 1'b0;
         em_mem_read_o  <= 1'b0;
         em_mem_write_o <= 1'b0;
      end else begin
         em_valid_o     <= de_valid_i;
         em_reg_write_o <= de_valid_i && de_reg_write_i;
         em_mem_read_o  <= de_valid_i && de_mem_read_i;
         em_mem_write_o <= de_valid_i && de_mem_write_i;
      end
   end

   always_ff @(posedge clk) begin
      em_pc_o         <= de_pc_i;
      em_rd_o         <= de_rd_i;
      em_result_o     <= result;
      em_store_data_o <= op_b;
   end

   // the slot behind a redirect is squashed in decode
   a_redirect_flush: assert property (
      @(posedge clk) disable iff (reset) redirect_o |=> !de_valid_i);

endmodule

`default_nettype wire

//--- fetch_unit.sv
`default_nettype none
`include "riscv_params.svh"

module fetch_unit #(
   parameter int IMEM_DEPTH = `RISCV_IMEM_DEPTH
) (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   run_i,
   input  wire                   imem_we_i,
   input  wire riscv_pkg::word_t imem_addr_i,
   input  wire riscv_pkg::word_t imem_wdata_i,
   input  wire                   redirect_i,
   input  wire riscv_pkg::word_t redirect_pc_i,
   output logic                  fd_valid_o,
   output riscv_pkg::word_t      fd_pc_o,
   output riscv_pkg::word_t      fd_instr_o
);
   import riscv_pkg::*;

   localparam int IDX_W = $clog2(IMEM_DEPTH);

   word_t pc_q;
   word_t imem [IMEM_DEPTH];

   // pc held at the reset value until run_i goes high
   always_ff @(posedge clk) begin
      if (reset || !run_i) begin
         pc_q <= `RISCV_RESET_PC;
      end else if (redirect_i) begin
         pc_q <= redirect_pc_i;
      end else begin
         pc_q <= pc_q + 32'd4;
      end
   end

   // program load port, word addressed
   always_ff @(posedge clk) begin
      if (imem_we_i) begin
         imem[imem_addr_i[IDX_W-1:0]] <= imem_wdata_i;
      end
   end

   // fetch/decode register
   always_ff @(posedge clk) begin
      if (reset) begin
         fd_valid_o <= 1'b0;
      end else begin
         fd_valid_o <= run_i && !redirect_i;
      end
   end

   always_ff @(posedge clk) begin
      fd_pc_o    <= pc_q;
      fd_instr_o <= imem[pc_q[IDX_W+1:2]];
   end

   // program is loaded only while the core is halted
   a_no_load_while_running: assert property (
      @(posedge clk) disable iff (reset) imem_we_i |-> !run_i);

endmodule

`default_nettype wire

//--- mem_stage.sv
`default_nettype none
`include "riscv_params.svh"

module mem_stage #(
   parameter int DMEM_DEPTH = `RISCV_DMEM_DEPTH
) (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       em_valid_i,
   input  wire riscv_pkg::word_t     em_pc_i,
   input  wire riscv_pkg::reg_addr_t em_rd_i,
   input  wire riscv_pkg::word_t     em_result_i,
   input  wire riscv_pkg::word_t     em_store_data_i,
   input  wire                       em_reg_write_i,
   input  wire                       em_mem_read_i,
   input  wire                       em_mem_write_i,
   output logic                      wb_we_o,
   output riscv_pkg::reg_addr_t      wb_rd_o,
   output riscv_pkg::word_t          wb_data_o,
   output logic                      retire_valid_o,
   output riscv_pkg::word_t          retire_pc_o,
   output logic                      retire_we_o,
   output riscv_pkg::reg_addr_t      retire_rd_o,
   output riscv_pkg::word_t          retire_data_o
);
   import riscv_pkg::*;

   localparam int IDX_W = $clog2(DMEM_DEPTH);

   word_t             dmem [DMEM_DEPTH];
   logic  [IDX_W-1:0] dmem_idx;
   word_t             load_data;
   logic              wb_valid_q, wb_we_q;
   word_t             wb_pc_q, wb_data_q;
   reg_addr_t         wb_rd_q;

   assign dmem_idx  = em_result_i[IDX_W+1:2];
   assign load_data = dmem[dmem_idx];

   always_ff @(posedge clk) begin
      if (em_valid_i && em_mem_write_i) begin
         dmem[dmem_idx] <= em_store_data_i;
      end
   end

   // memory/writeback register
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_valid_q <= 1'b0;
         wb_we_q    <= 1'b0;
      end else begin
         wb_valid_q <= em_valid_i;
         wb_we_q    <= em_valid_i && em_reg_write_i && em_rd_i != '0;
      end
   end

   always_ff @(posedge clk) begin
      wb_pc_q   <= em_pc_i;
      wb_rd_q   <= em_rd_i;
      wb_data_q <= em_mem_read_i ? load_data : em_result_i;
   end

   // writeback fields are the retire port
   assign wb_we_o        = wb_we_q;
   assign wb_rd_o        = wb_rd_q;
   assign wb_data_o      = wb_data_q;
   assign retire_valid_o = wb_valid_q;
   assign retire_pc_o    = wb_pc_q;
   assign retire_we_o    = wb_we_q;
   assign retire_rd_o    = wb_rd_q;
   assign retire_data_o  = wb_data_q;

   a_dmem_addr_ok: assert property (
      @(posedge clk) disable iff (reset)
      (em_valid_i && (em_mem_read_i || em_mem_write_i)) |->
         (em_result_i[1:0] == 2'b00 && em_result_i < DMEM_DEPTH * 4));

endmodule

`default_nettype wire

//--- project.f
+incdir+.
riscv_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
mem_stage.sv
riscv_core.sv
riscv_tb.sv

//--- reg_file.sv
`default_nettype none

module reg_file (
   input  wire                       clk,
   input  wire                       reset,
   input  wire riscv_pkg::reg_addr_t rs1_addr_i,
   input  wire riscv_pkg::reg_addr_t rs2_addr_i,
   output riscv_pkg::word_t          rs1_data_o,
   output riscv_pkg::word_t          rs2_data_o,
   input  wire                       we_i,
   input  wire riscv_pkg::reg_addr_t rd_i,
   input  wire riscv_pkg::word_t     wd_i
);
   import riscv_pkg::*;

   word_t regs [32];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && rd_i != '0) begin
         regs[rd_i] <= wd_i;
      end
   end

   // x0 reads as zero, a same-cycle write is passed straight through
   always_comb begin
      if (rs1_addr_i == '0) begin
         rs1_data_o = '0;
      end else if (we_i && rd_i == rs1_addr_i) begin
         rs1_data_o = wd_i;
      end else begin
         rs1_data_o = regs[rs1_addr_i];
      end
   end

   always_comb begin
      if (rs2_addr_i == '0) begin
         rs2_data_o = '0;
      end else if (we_i && rd_i == rs2_addr_i) begin
         rs2_data_o = wd_i;
      end else begin
         rs2_data_o = regs[rs2_addr_i];
      end
   end

   a_write_addr_known: assert property (
      @(posedge clk) disable iff (reset) we_i |-> !$isunknown(rd_i));

endmodule

`default_nettype wire

//--- riscv_core.sv
`default_nettype none

module riscv_core (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   run_i,
   input  wire                   imem_we_i,
   input  wire riscv_pkg::word_t imem_addr_i,
   input  wire riscv_pkg::word_t imem_wdata_i,
   output logic                  retire_valid_o,
   output riscv_pkg::word_t      retire_pc_o,
   output logic                  retire_we_o,
   output riscv_pkg::reg_addr_t  retire_rd_o,
   output riscv_pkg::word_t      retire_data_o
);
   import riscv_pkg::*;

   // fetch to decode
   logic      fd_valid;
   word_t     fd_pc, fd_instr;

   // decode to register file
   reg_addr_t rs1_addr, rs2_addr;
   word_t     rs1_data, rs2_data;

   // decode to execute
   logic      de_valid, de_use_imm, de_reg_write, de_mem_read, de_mem_write;
   logic      de_branch, de_branch_ne, de_jump, de_lui;
   word_t     de_pc, de_op_a, de_op_b_reg, de_imm;
   reg_addr_t de_rs1, de_rs2, de_rd;
   alu_op_t   de_alu_op;

   // execute to memory
   logic      em_valid, em_reg_write, em_mem_read, em_mem_write;
   word_t     em_pc, em_result, em_store_data;
   reg_addr_t em_rd;

   // writeback and redirect feedback
   logic      wb_we, redirect;
   reg_addr_t wb_rd;
   word_t     wb_data, redirect_pc;

   fetch_unit u_fetch (
      .clk(clk), .reset(reset), .run_i(run_i),
      .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
      .redirect_i(redirect), .redirect_pc_i(redirect_pc),
      .fd_valid_o(fd_valid), .fd_pc_o(fd_pc), .fd_instr_o(fd_instr)
   );

   decode_unit u_decode (
      .clk(clk), .reset(reset), .redirect_i(redirect),
      .fd_valid_i(fd_valid), .fd_pc_i(fd_pc), .fd_instr_i(fd_instr),
      .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
      .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
      .de_valid_o(de_valid), .de_pc_o(de_pc), .de_rs1_o(de_rs1), .de_rs2_o(de_rs2),
      .de_rd_o(de_rd), .de_op_a_o(de_op_a), .de_op_b_reg_o(de_op_b_reg),
      .de_imm_o(de_imm), .de_alu_op_o(de_alu_op), .de_use_imm_o(de_use_imm),
      .de_reg_write_o(de_reg_write), .de_mem_read_o(de_mem_read),
      .de_mem_write_o(de_mem_write), .de_branch_o(de_branch),
      .de_branch_ne_o(de_branch_ne), .de_jump_o(de_jump), .de_lui_o(de_lui)
   );

   reg_file u_regs (
      .clk(clk), .reset(reset),
      .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
      .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
      .we_i(wb_we), .rd_i(wb_rd), .wd_i(wb_data)
   );

   execute_unit u_execute (
      .clk(clk), .reset(reset),
      .de_valid_i(de_valid), .de_pc_i(de_pc), .de_rs1_i(de_rs1), .de_rs2_i(de_rs2),
      .de_rd_i(de_rd), .de_op_a_i(de_op_a), .de_op_b_reg_i(de_op_b_reg),
      .de_imm_i(de_imm), .de_alu_op_i(de_alu_op), .de_use_imm_i(de_use_imm),
      .de_reg_write_i(de_reg_write), .de_mem_read_i(de_mem_read),
      .de_mem_write_i(de_mem_write), .de_branch_i(de_branch),
      .de_branch_ne_i(de_branch_ne), .de_jump_i(de_jump), .de_lui_i(de_lui),
      .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
      .redirect_o(redirect), .redirect_pc_o(redirect_pc),
      .em_valid_o(em_valid), .em_pc_o(em_pc), .em_rd_o(em_rd),
      .em_result_o(em_result), .em_store_data_o(em_store_data),
      .em_reg_write_o(em_reg_write), .em_mem_read_o(em_mem_read),
      .em_mem_write_o(em_mem_write)
   );

   mem_stage u_mem (
      .clk(clk), .reset(reset),
      .em_valid_i(em_valid), .em_pc_i(em_pc), .em_rd_i(em_rd),
      .em_result_i(em_result), .em_store_data_i(em_store_data),
      .em_reg_write_i(em_reg_write), .em_mem_read_i(em_mem_read),
      .em_mem_write_i(em_mem_write),
      .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
      .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
      .retire_we_o(retire_we_o), .retire_rd_o(retire_rd_o),
      .retire_data_o(retire_data_o)
   );

endmodule

`default_nettype wire

//--- riscv_params.svh
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// memory sizes in 32-bit words
`define RISCV_IMEM_DEPTH 256
`define RISCV_DMEM_DEPTH 256

// first fetched address after reset or while halted
`define RISCV_RESET_PC   32'h0000_0000

// major opcodes, instr[6:0]
`define OPC_OP           7'b0110011
`define OPC_OPIMM        7'b0010011
`define OPC_LUI          7'b0110111
`define OPC_LOAD         7'b0000011
`define OPC_STORE        7'b0100011
`define OPC_BRANCH       7'b1100011
`define OPC_JAL          7'b1101111

// alu operation codes
`define ALU_ADD          4'd0
`define ALU_SUB          4'd1
`define ALU_AND          4'd2
`define ALU_OR           4'd3
`define ALU_XOR          4'd4
`define ALU_SLT          4'd5
`define ALU_PASSB        4'd6

`endif

//--- riscv_pkg.sv
`default_nettype none

package riscv_pkg;

   // data word, byte address or instruction
   typedef logic [31:0] word_t;

   // architectural register index
   typedef logic [4:0] reg_addr_t;

   // alu selector, codes come from riscv_params.svh
   typedef logic [3:0] alu_op_t;

   // operand source in execute
   typedef logic [1:0] fwd_sel_t;

   // value read in decode
   localparam fwd_sel_t FWD_PIPE = 2'd0;
   // result of the instruction now in the memory stage
   localparam fwd_sel_t FWD_MEM  = 2'd1;
   // result of the instruction now in writeback
   localparam fwd_sel_t FWD_WB   = 2'd2;

endpackage

`default_nettype wire

//--- riscv_tb.sv
`default_nettype none
`include "riscv_params.svh"

module riscv_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import riscv_pkg::*;

   localparam int NUM_PROGS = 2;

   // funct3 and funct7 values of the supported ops
   localparam int F3_ADD = 0;
   localparam int F3_SLT = 2;
   localparam int F3_XOR = 4;
   localparam int F3_OR  = 6;
   localparam int F3_AND = 7;
   localparam int F3_BEQ = 0;
   localparam int F3_BNE = 1;
   localparam int F7_SUB = 32;

   logic      clk = 1'b0;
   logic      reset;
   logic      run_i;
   logic      imem_we_i;
   word_t     imem_addr_i;
   word_t     imem_wdata_i;
   logic      retire_valid_o;
   word_t     retire_pc_o;
   logic      retire_we_o;
   reg_addr_t retire_rd_o;
   word_t     retire_data_o;

   // program words and expected register writes, all programs back to back
   word_t     prog_q [$];
   reg_addr_t exp_rd_q [$];
   word_t     exp_val_q [$];
   int        prog_start [NUM_PROGS];
   int        prog_len [NUM_PROGS];
   int        exp_start [NUM_PROGS];
   int        exp_count [NUM_PROGS];

   int   errors = 0;
   int   checked = 0;
   int   exp_idx = 0;
   int   exp_end = 0;
   logic loading = 1'b0;
   logic checking = 1'b0;
   logic first_pending = 1'b0;
   logic tables_ready = 1'b0;

   riscv_core UUT (
      .clk(clk), .reset(reset), .run_i(run_i),
      .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
      .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
      .retire_we_o(retire_we_o), .retire_rd_o(retire_rd_o),
      .retire_data_o(retire_data_o)
   );

   always #4 clk = ~clk;

   // instruction encoders, one per RV32I format
   function automatic word_t reg_op(input int f7, input int f3, input int rd,
                                    input int rs1, input int rs2);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP};
   endfunction

   function automatic word_t imm_op(input int f3, input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OPIMM};
   endfunction

   function automatic word_t load_word(input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], `OPC_LOAD};
   endfunction

   function automatic word_t store_word(input int rs2, input int rs1, input int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OPC_STORE};
   endfunction

   function automatic word_t branch(input int f3, input int rs1, input int rs2, input int imm);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
              `OPC_BRANCH};
   endfunction

   function automatic word_t jump(input int rd, input int imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OPC_JAL};
   endfunction

   function automatic word_t upper(input int rd, input int imm20);
      return {imm20[19:0], rd[4:0], `OPC_LUI};
   endfunction

   task automatic expect_write(input int rd, input word_t val);
      exp_rd_q.push_back(rd[4:0]);
      exp_val_q.push_back(val);
   endtask

   task automatic fill_tables();
      // alu ops, forwarding at distance one and two, x0 handling
      prog_start[0] = prog_q.size();
      exp_start[0]  = exp_rd_q.size();
      prog_q.push_back(imm_op(F3_ADD, 1, 0, 5));
      prog_q.push_back(imm_op(F3_ADD, 2, 0, -3));
      prog_q.push_back(reg_op(0, F3_ADD, 3, 1, 2));
      prog_q.push_back(reg_op(F7_SUB, F3_ADD, 4, 2, 1));
      prog_q.push_back(reg_op(0, F3_SLT, 5, 2, 1));
      prog_q.push_back(imm_op(F3_SLT, 6, 2, -1));
      prog_q.push_back(upper(7, 'h12345));
      prog_q.push_back(imm_op(F3_OR, 8, 7, 'h678));
      prog_q.push_back(imm_op(F3_XOR, 9, 8, -1));
      prog_q.push_back(reg_op(0, F3_AND, 10, 9, 8));
      prog_q.push_back(imm_op(F3_AND, 11, 8, 'h0f0));
      prog_q.push_back(reg_op(0, F3_OR, 12, 4, 3));
      prog_q.push_back(reg_op(0, F3_XOR, 13, 12, 4));
      prog_q.push_back(imm_op(F3_ADD, 0, 1, 7));
      prog_q.push_back(reg_op(0, F3_ADD, 14, 0, 1));
      prog_q.push_back(reg_op(0, F3_SLT, 15, 1, 2));
      prog_q.push_back(jump(0, 0));
      expect_write(1, 32'h0000_0005);
      expect_write(2, 32'hffff_fffd);
      expect_write(3, 32'h0000_0002);
      expect_write(4, 32'hffff_fff8);
      expect_write(5, 32'h0000_0001);
      expect_write(6, 32'h0000_0001);
      expect_write(7, 32'h1234_5000);
      expect_write(8, 32'h1234_5678);
      expect_write(9, 32'hedcb_a987);
      expect_write(10, 32'h0000_0000);
      expect_write(11, 32'h0000_0070);
      expect_write(12, 32'hffff_fffa);
      expect_write(13, 32'h0000_0002);
      expect_write(14, 32'h0000_0005);
      expect_write(15, 32'h0000_0000);
      prog_len[0]  = prog_q.size() - prog_start[0];
      exp_count[0] = exp_rd_q.size() - exp_start[0];

      // store then load, taken and not taken branches, jal link
      prog_start[1] = prog_q.size();
      exp_start[1]  = exp_rd_q.size();
      prog_q.push_back(imm_op(F3_ADD, 1, 0, 'h40));
      prog_q.push_back(upper(2, 'habcde));
      prog_q.push_back(imm_op(F3_ADD, 2, 2, 'h123));
      prog_q.push_back(store_word(2, 1, 4));
      prog_q.push_back(load_word(3, 1, 4));
      prog_q.push_back(imm_op(F3_ADD, 4, 0, 1));
      prog_q.push_back(reg_op(0, F3_ADD, 5, 3, 4));
      prog_q.push_back(branch(F3_BEQ, 4, 4, 12));
      prog_q.push_back(imm_op(F3_ADD, 6, 0, 99));
      prog_q.push_back(imm_op(F3_ADD, 7, 0, 99));
      prog_q.push_back(branch(F3_BNE, 4, 4, 8));
      prog_q.push_back(imm_op(F3_ADD, 8, 0, 11));
      prog_q.push_back(branch(F3_BNE, 8, 4, 12));
      prog_q.push_back(imm_op(F3_ADD, 9, 0, 99));
      prog_q.push_back(imm_op(F3_ADD, 10, 0, 99));
      prog_q.push_back(jump(11, 12));
      prog_q.push_back(imm_op(F3_ADD, 12, 0, 99));
      prog_q.push_back(imm_op(F3_ADD, 13, 0, 99));
      prog_q.push_back(branch(F3_BEQ, 0, 1, 8));
      prog_q.push_back(imm_op(F3_ADD, 14, 11, 1));
      prog_q.push_back(jump(0, 0));
      expect_write(1, 32'h0000_0040);
      expect_write(2, 32'habcd_e000);
      expect_write(2, 32'habcd_e123);
      expect_write(3, 32'habcd_e123);
      expect_write(4, 32'h0000_0001);
      expect_write(5, 32'habcd_e124);
      expect_write(8, 32'h0000_000b);
      expect_write(11, 32'h0000_0040);
      expect_write(14, 32'h0000_0041);
      prog_len[1]  = prog_q.size() - prog_start[1];
      exp_count[1] = exp_rd_q.size() - exp_start[1];
   endtask

   task automatic run_program(input int p);
      int i;
      // halted core, reset pulse, then load through the imem port
      checking = 1'b0;
      run_i <= 1'b0;
      reset <= 1'b1;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      loading = 1'b1;
      for (i = 0; i < prog_len[p]; i++) begin
         @(posedge clk);
         imem_we_i    <= 1'b1;
         imem_addr_i  <= i;
         imem_wdata_i <= prog_q[prog_start[p] + i];
      end
      @(posedge clk);
      imem_we_i     <= 1'b0;
      exp_idx       = exp_start[p];
      exp_end       = exp_start[p] + exp_count[p];
      first_pending = 1'b1;
      loading       = 1'b0;
      checking      = 1'b1;
      run_i         <= 1'b1;
      wait (exp_idx == exp_end);
      // keep watching the closing loop for stray writes
      repeat (12) @(posedge clk);
      checking = 1'b0;
   endtask

   // retire checker, sampled away from the active edge
   always @(negedge clk) begin
      if (loading) begin
         assert (!retire_valid_o) else begin
            errors = errors + 1;
            $display("ERROR at %0d ns: retire_valid_o high while the core is halted", $time);
         end
      end else if (checking && retire_valid_o) begin
         if (first_pending) begin
            first_pending = 1'b0;
            assert (retire_pc_o == 32'h0) else begin
               errors = errors + 1;
               $display("ERROR at %0d ns: first retired pc %h, expected 0", $time, retire_pc_o);
            end
         end
         if (retire_we_o) begin
            assert (retire_rd_o != '0) else begin
               errors = errors + 1;
               $display("ERROR at %0d ns: write to x0 retired at pc %h", $time, retire_pc_o);
            end
            assert (exp_idx < exp_end) else begin
               errors = errors + 1;
               $display("ERROR at %0d ns: unexpected write x%0d = %h at pc %h",
                        $time, retire_rd_o, retire_data_o, retire_pc_o);
            end
            if (exp_idx < exp_end) begin
               assert (retire_rd_o == exp_rd_q[exp_idx] &&
                       retire_data_o == exp_val_q[exp_idx]) else begin
                  errors = errors + 1;
                  $display("ERROR at %0d ns: expected x%0d = %h, got x%0d = %h at pc %h",
                           $time, exp_rd_q[exp_idx], exp_val_q[exp_idx],
                           retire_rd_o, retire_data_o, retire_pc_o);
               end
               exp_idx = exp_idx + 1;
               checked = checked + 1;
            end
         end
      end
   end

   initial begin : watchdog
      int total_words;
      int limit_ns;
      wait (tables_ready);
      total_words = 0;
      for (int p = 0; p < NUM_PROGS; p++) begin
         total_words = total_words + prog_len[p];
      end
      limit_ns = (total_words + 40 * NUM_PROGS) * 8 * 8;
      #(limit_ns);
      $display("timeout: the run did not finish within %0d ns, %0d errors so far",
               limit_ns, errors);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      reset        = 1'b1;
      run_i        = 1'b0;
      imem_we_i    = 1'b0;
      imem_addr_i  = '0;
      imem_wdata_i = '0;
      fill_tables();
      tables_ready = 1'b1;
      for (int p = 0; p < NUM_PROGS; p++) begin
         run_program(p);
      end
      $display("riscv_tb: %0d register writes checked, %0d errors", checked, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build riscv_tb with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module riscv_tb -f project.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vriscv_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "TESTBENCH PASSED"; then
   exit 0
fi
echo "simulation did not report a pass"
exit 1
